// ==== Makefile ====
TOP = rv_exec_slice_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f rv_exec_slice.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f rv_exec_slice.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_decoder (
  input  rv_pipe_pkg::fetch_pkt_t fetch_i,
  input  logic [`RV_XLEN-1:0]     rdata1_i,
  input  logic [`RV_XLEN-1:0]     rdata2_i,
  input  logic                    fwd_valid_i,
  input  logic [`RV_REG_AW-1:0]   fwd_rd_i,
  input  logic [`RV_XLEN-1:0]     fwd_data_i,
  output logic [`RV_REG_AW-1:0]   rs1_o,
  output logic [`RV_REG_AW-1:0]   rs2_o,
  output rv_pipe_pkg::dec_pkt_t   dec_o
);
  import rv_isa_pkg::*;

  logic [31:0]           instr;
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`RV_REG_AW-1:0] rd;
  logic [`RV_XLEN-1:0]   imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [`RV_XLEN-1:0]   src1, src2;
  logic                  writes_rd;

  assign instr  = fetch_i.instr;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1_o  = instr[19:15];
  assign rs2_o  = instr[24:20];

  assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};

  // The output stage holds the only older instruction whose result is not yet written back
  assign src1 = (fwd_valid_i && fwd_rd_i == rs1_o) ? fwd_data_i : rdata1_i;
  assign src2 = (fwd_valid_i && fwd_rd_i == rs2_o) ? fwd_data_i : rdata2_i;

  always_comb begin
    dec_o         = '0;
    dec_o.pc      = fetch_i.pc;
    dec_o.rd      = rd;
    dec_o.alu_op  = ALU_ADD;
    dec_o.br_cond = BR_BEQ;
    writes_rd     = 1'b0;
    unique case (opcode)
      OPC_LUI: begin
        dec_o.op2 = imm_u;  // op1 stays zero
        writes_rd = 1'b1;
      end
      OPC_AUIPC: begin
        dec_o.op1 = fetch_i.pc;
        dec_o.op2 = imm_u;
        writes_rd = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        dec_o.op1     = fetch_i.pc;  // Link value pc+4 comes out of the ALU
        dec_o.op2     = `RV_XLEN'd4;
        dec_o.jbase   = (opcode == OPC_JAL) ? fetch_i.pc : src1;
        dec_o.imm     = (opcode == OPC_JAL) ? imm_j : imm_i;
        dec_o.is_jump = 1'b1;
        writes_rd     = 1'b1;
      end
      OPC_BRANCH: begin
        dec_o.op1       = src1;
        dec_o.op2       = src2;
        dec_o.jbase     = fetch_i.pc;
        dec_o.imm       = imm_b;
        dec_o.br_cond   = br_cond_e'(funct3);
        dec_o.is_branch = 1'b1;
        dec_o.illegal   = (funct3[2:1] == 2'b01);
      end
      OPC_LOAD: begin
        dec_o.op1    = src1;
        dec_o.op2    = imm_i;
        dec_o.imm    = imm_i;
        dec_o.mem_re = 1'b1;  // No data memory, so rd is never written
      end
      OPC_STORE: begin
        dec_o.op1        = src1;
        dec_o.op2        = imm_s;
        dec_o.imm        = imm_s;
        dec_o.store_data = src2;
        dec_o.mem_we     = 1'b1;
      end
      OPC_OP_IMM: begin
        dec_o.op1    = src1;
        dec_o.op2    = imm_i;
        // funct7[5] only picks SRAI, otherwise it is part of the immediate
        dec_o.alu_op = alu_op_e'({(funct3 == 3'b101) ? funct7[5] : 1'b0, funct3});
        writes_rd    = 1'b1;
      end
      OPC_OP: begin
        dec_o.op1     = src1;
        dec_o.op2     = src2;
        dec_o.alu_op  = alu_op_e'({funct7[5], funct3});
        dec_o.illegal = (funct7 != 7'h00) &&
                        !(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
        writes_rd     = 1'b1;
      end
      default: dec_o.illegal = 1'b1;
    endcase
    dec_o.rd_we = writes_rd && rd != '0 && !dec_o.illegal;
  end

endmodule

// ==== rtl/rv_exec_slice.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_exec_slice (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid_i,
  input  rv_pipe_pkg::fetch_pkt_t in_pkt_i,
  output logic                    in_ready_o,
  output logic                    out_valid_o,
  output rv_pipe_pkg::res_pkt_t   out_pkt_o,
  input  logic                    out_ready_i
);
  import rv_pipe_pkg::*;

  fetch_pkt_t            fetch;
  dec_pkt_t              dec;
  res_pkt_t              res;
  logic                  fetch_valid;
  logic                  out_stage_ready;
  logic [`RV_REG_AW-1:0] rs1, rs2;
  logic [`RV_XLEN-1:0]   rdata1, rdata2;
  logic                  fwd_valid;
  logic                  wb_en;

  assign fwd_valid = out_valid_o && out_pkt_o.rd_we;
  assign wb_en     = out_valid_o && out_ready_i && out_pkt_o.rd_we;  // Retire on output transfer

  rv_stage_reg #(.payload_t(fetch_pkt_t)) u_in_stage (
    .clk     (clk),
    .rst     (rst),
    .valid_i (in_valid_i),
    .data_i  (in_pkt_i),
    .ready_o (in_ready_o),
    .valid_o (fetch_valid),
    .data_o  (fetch),
    .ready_i (out_stage_ready)
  );

  rv_decoder u_decoder (
    .fetch_i     (fetch),
    .rdata1_i    (rdata1),
    .rdata2_i    (rdata2),
    .fwd_valid_i (fwd_valid),
    .fwd_rd_i    (out_pkt_o.rd),
    .fwd_data_i  (out_pkt_o.result),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .dec_o       (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (wb_en),
    .waddr_i  (out_pkt_o.rd),
    .wdata_i  (out_pkt_o.result)
  );

  rv_execute u_execute (
    .dec_i (dec),
    .res_o (res)
  );

  rv_stage_reg #(.payload_t(res_pkt_t)) u_out_stage (
    .clk     (clk),
    .rst     (rst),
    .valid_i (fetch_valid),
    .data_i  (res),
    .ready_o (out_stage_ready),
    .valid_o (out_valid_o),
    .data_o  (out_pkt_o),
    .ready_i (out_ready_i)
  );

endmodule

// ==== rtl/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_execute (
  input  rv_pipe_pkg::dec_pkt_t dec_i,
  output rv_pipe_pkg::res_pkt_t res_o
);
  import rv_isa_pkg::*;

  logic [`RV_XLEN-1:0] alu_out;
  logic [`RV_XLEN-1:0] target_sum;
  logic [4:0]          shamt;
  logic                eq, lt, ltu;
  logic                cond_true;

  assign shamt = dec_i.op2[4:0];

  always_comb begin
    unique case (dec_i.alu_op)
      ALU_ADD:  alu_out = dec_i.op1 + dec_i.op2;
      ALU_SUB:  alu_out = dec_i.op1 - dec_i.op2;
      ALU_SLL:  alu_out = dec_i.op1 << shamt;
      ALU_SLT:  alu_out = `RV_XLEN'($signed(dec_i.op1) < $signed(dec_i.op2));
      ALU_SLTU: alu_out = `RV_XLEN'(dec_i.op1 < dec_i.op2);
      ALU_XOR:  alu_out = dec_i.op1 ^ dec_i.op2;
      ALU_SRL:  alu_out = dec_i.op1 >> shamt;
      ALU_SRA:  alu_out = $signed(dec_i.op1) >>> shamt;
      ALU_OR:   alu_out = dec_i.op1 | dec_i.op2;
      ALU_AND:  alu_out = dec_i.op1 & dec_i.op2;
      default:  alu_out = '0;
    endcase
  end

  // Branches compare the register operands
  assign eq  = (dec_i.op1 == dec_i.op2);
  assign lt  = ($signed(dec_i.op1) < $signed(dec_i.op2));
  assign ltu = (dec_i.op1 < dec_i.op2);

  always_comb begin
    unique case (dec_i.br_cond)
      BR_BEQ:  cond_true = eq;
      BR_BNE:  cond_true = !eq;
      BR_BLT:  cond_true = lt;
      BR_BGE:  cond_true = !lt;
      BR_BLTU: cond_true = ltu;
      BR_BGEU: cond_true = !ltu;
      default: cond_true = 1'b0;
    endcase
  end

  assign target_sum = dec_i.jbase + dec_i.imm;

  always_comb begin
    res_o            = '0;
    res_o.pc         = dec_i.pc;
    res_o.rd         = dec_i.rd;
    res_o.rd_we      = dec_i.rd_we;
    res_o.result     = dec_i.is_branch ? '0 : alu_out;
    res_o.redirect   = dec_i.is_jump || (dec_i.is_branch && cond_true);
    res_o.mem_re     = dec_i.mem_re;
    res_o.mem_we     = dec_i.mem_we;
    res_o.store_data = dec_i.store_data;
    res_o.illegal    = dec_i.illegal;
    if (dec_i.is_jump) begin
      // JAL targets are already even, so clearing bit 0 only matters for JALR
      res_o.target = {target_sum[`RV_XLEN-1:1], 1'b0};
    end else if (dec_i.is_branch) begin
      res_o.target = target_sum;  // Reported even when not taken
    end
    if (dec_i.mem_re || dec_i.mem_we) begin
      res_o.mem_addr = dec_i.op1 + dec_i.imm;
    end
  end

endmodule

// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // RV32I major opcodes handled by the slice
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // Encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  // Branch funct3 values, 010 and 011 are reserved
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_cond_e;

endpackage

// ==== rtl/rv_pipe_pkg.sv ====
`include "rv_settings.svh"

package rv_pipe_pkg;

  typedef struct packed {
    logic [31:0]         instr;
    logic [`RV_XLEN-1:0] pc;
  } fetch_pkt_t;

  // Operands are already resolved, forwarding included
  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   op1;
    logic [`RV_XLEN-1:0]   op2;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_XLEN-1:0]   jbase;       // pc for JAL and branches, rs1 for JALR
    logic [`RV_XLEN-1:0]   store_data;
    rv_isa_pkg::alu_op_e   alu_op;
    rv_isa_pkg::br_cond_e  br_cond;
    logic [`RV_REG_AW-1:0] rd;
    logic                  rd_we;
    logic                  is_branch;
    logic                  is_jump;
    logic                  mem_re;
    logic                  mem_we;
    logic                  illegal;
  } dec_pkt_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_REG_AW-1:0] rd;
    logic                  rd_we;
    logic [`RV_XLEN-1:0]   result;
    logic                  redirect;
    logic [`RV_XLEN-1:0]   target;
    logic                  mem_re;
    logic                  mem_we;
    logic [`RV_XLEN-1:0]   mem_addr;
    logic [`RV_XLEN-1:0]   store_data;
    logic                  illegal;
  } res_pkt_t;

endpackage

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_REG_AW-1:0] raddr1_i,
  input  logic [`RV_REG_AW-1:0] raddr2_i,
  output logic [`RV_XLEN-1:0]   rdata1_o,
  output logic [`RV_XLEN-1:0]   rdata2_o,
  input  logic                  we_i,
  input  logic [`RV_REG_AW-1:0] waddr_i,
  input  logic [`RV_XLEN-1:0]   wdata_i
);

  logic [`RV_XLEN-1:0] regs [`RV_NREG];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin  // x0 is hardwired
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== rtl/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path width of the slice
`define RV_XLEN 32

// Architectural register file
`define RV_NREG 32
`define RV_REG_AW 5

`endif

// ==== rtl/rv_stage_reg.sv ====
`timescale 1ns/1ps

module rv_stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     ready_i
);

  // Free when empty or when the held entry leaves on this edge
  assign ready_o = !valid_o || ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      data_o <= data_i;
    end
  end

endmodule

// ==== rv_exec_slice.f ====
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/rv_stage_reg.sv
rtl/rv_regfile.sv
rtl/rv_decoder.sv
rtl/rv_execute.sv
rtl/rv_exec_slice.sv
verification/rv_exec_asserts.sv
verification/rv_exec_checker.sv
verification/rv_exec_slice_tb.sv

// ==== verification/rv_exec_asserts.sv ====
`timescale 1ns/1ps

module rv_exec_asserts (
  input logic                    clk,
  input logic                    rst,
  input logic                    fetch_valid_i,
  input rv_pipe_pkg::fetch_pkt_t fetch_i,
  input logic                    fetch_ready_i,
  input logic                    out_valid_o,
  input rv_pipe_pkg::res_pkt_t   out_pkt_o,
  input logic                    out_ready_i
);

  int failures = 0;

  // Link from the input stage into the output stage
  fetch_hold: assert property (@(posedge clk) disable iff (rst)
    fetch_valid_i && !fetch_ready_i |=> fetch_valid_i && $stable(fetch_i))
    else begin
      $error("Decoder input packet changed while stalled");
      failures++;
    end

  out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_pkt_o))
    else begin
      $error("Output packet changed while stalled");
      failures++;
    end

  // Both stages come out of reset empty
  out_empty_after_rst: assert property (@(posedge clk) rst |=> !out_valid_o)
    else begin
      $error("out_valid_o high right after reset");
      failures++;
    end

  no_x0_write: assert property (@(posedge clk) disable iff (rst)
    out_valid_o |-> !(out_pkt_o.rd_we && out_pkt_o.rd == '0))
    else begin
      $error("Packet reports a write to x0");
      failures++;
    end

endmodule

bind rv_exec_slice rv_exec_asserts u_asserts (
  .clk           (clk),
  .rst           (rst),
  .fetch_valid_i (fetch_valid),
  .fetch_i       (fetch),
  .fetch_ready_i (out_stage_ready),
  .out_valid_o   (out_valid_o),
  .out_pkt_o     (out_pkt_o),
  .out_ready_i   (out_ready_i)
);

// ==== verification/rv_exec_checker.sv ====
`timescale 1ns/1ps

module rv_exec_checker #(
  parameter int TRACE_LEN  = 1,
  parameter int TRACE_COLS = 7
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  out_valid_i,
  input  rv_pipe_pkg::res_pkt_t out_pkt_i,
  input  logic                  out_ready_i,
  input  logic [31:0]           trace_i [TRACE_LEN*TRACE_COLS],
  output int                    checked_o,
  output int                    errors_o
);

  int checked = 0;
  int errors = 0;
  int pkt_errors;

  assign checked_o = checked;
  assign errors_o  = errors;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
      pkt_errors++;
    end
  endtask

  // Flags column holds illegal, mem_we, mem_re, redirect and rd_we one per nibble, rd below
  task automatic check_packet(input int n);
    int          base;
    logic [31:0] flags;
    base       = n * TRACE_COLS;
    flags      = trace_i[base+2];
    pkt_errors = 0;
    compare("pc", trace_i[base+1], out_pkt_i.pc);
    compare("rd_we", 32'(flags[8]), 32'(out_pkt_i.rd_we));
    if (flags[8]) begin  // rd only means something when rd is written
      compare("rd", 32'(flags[4:0]), 32'(out_pkt_i.rd));
    end
    if (!flags[16] && !flags[20]) begin  // Result is unspecified for loads and stores
      compare("result", trace_i[base+3], out_pkt_i.result);
    end
    compare("redirect", 32'(flags[12]), 32'(out_pkt_i.redirect));
    compare("target", trace_i[base+4], out_pkt_i.target);
    compare("mem_re", 32'(flags[16]), 32'(out_pkt_i.mem_re));
    compare("mem_we", 32'(flags[20]), 32'(out_pkt_i.mem_we));
    compare("mem_addr", trace_i[base+5], out_pkt_i.mem_addr);
    compare("store_data", trace_i[base+6], out_pkt_i.store_data);
    compare("illegal", 32'(flags[24]), 32'(out_pkt_i.illegal));
    errors += pkt_errors;
    $display("Packet %0d pc %h instr %h: %s", n, out_pkt_i.pc, trace_i[base],
             (pkt_errors == 0) ? "ok" : "mismatch");
  endtask

  task automatic print_summary();
    $display("Checked %0d of %0d packets, %0d errors", checked, TRACE_LEN, errors);
  endtask

  // Mid-cycle the handshake for the next rising edge is settled
  always @(negedge clk) begin
    if (!rst && out_valid_i && out_ready_i) begin
      if (checked >= TRACE_LEN) begin
        $display("Extra packet with pc %h arrived after the end of the trace", out_pkt_i.pc);
        errors++;
      end else begin
        check_packet(checked);
      end
      checked++;
    end
  end

endmodule

// ==== verification/rv_exec_slice_tb.sv ====
`timescale 1ns/1ps

module rv_exec_slice_tb;
  import rv_pipe_pkg::*;

  localparam int TRACE_LEN   = 31;
  localparam int TRACE_COLS  = 7;
  localparam int STALL_LIMIT = 100;

  logic        clk = 1'b0;
  logic        rst;
  logic        in_valid;
  fetch_pkt_t  in_pkt;
  logic        in_ready;
  logic        out_valid;
  res_pkt_t    out_pkt;
  logic        out_ready;
  logic [31:0] trace [TRACE_LEN*TRACE_COLS];
  int          checked;
  int          errors;
  int          idx;
  int          wait_cycles;
  logic        accepted;
  logic        timed_out;

  always #4 clk = ~clk;

  rv_exec_slice dut (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid),
    .in_pkt_i    (in_pkt),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_pkt_o   (out_pkt),
    .out_ready_i (out_ready)
  );

  rv_exec_checker #(.TRACE_LEN(TRACE_LEN), .TRACE_COLS(TRACE_COLS)) u_checker (
    .clk         (clk),
    .rst         (rst),
    .out_valid_i (out_valid),
    .out_pkt_i   (out_pkt),
    .out_ready_i (out_ready),
    .trace_i     (trace),
    .checked_o   (checked),
    .errors_o    (errors)
  );

  // Steps to just after the next rising edge and draws new back-pressure (ready 3 times in 4)
  task automatic next_cycle();
    @(posedge clk);
    #1;
    out_ready = ($urandom_range(3) != 0);
  endtask

  initial begin
    void'($urandom(32'h5c6d));
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_pkt    = '0;
    out_ready = 1'b0;
    timed_out = 1'b0;
    $readmemh("verification/rv_exec_trace.txt", trace);
    repeat (10) next_cycle();
    rst = 1'b0;

    idx         = 0;
    wait_cycles = 0;
    while (idx < TRACE_LEN && wait_cycles < STALL_LIMIT) begin
      in_valid     = 1'b1;
      in_pkt.instr = trace[idx*TRACE_COLS];
      in_pkt.pc    = trace[idx*TRACE_COLS+1];
      @(negedge clk);
      accepted = in_ready;  // Transfer happens on the coming rising edge
      next_cycle();
      if (accepted) begin
        idx++;
        wait_cycles = 0;
      end else begin
        wait_cycles++;
      end
    end
    in_valid = 1'b0;
    if (idx < TRACE_LEN) begin
      $display("Timeout: in_ready_o stayed low for %0d cycles at instruction %0d",
               STALL_LIMIT, idx);
      timed_out = 1'b1;
    end

    wait_cycles = 0;
    while (!timed_out && checked < TRACE_LEN && wait_cycles < STALL_LIMIT) begin
      next_cycle();
      wait_cycles++;
    end
    if (!timed_out && checked < TRACE_LEN) begin
      $display("Timeout: only %0d of %0d packets left the DUT", checked, TRACE_LEN);
      timed_out = 1'b1;
    end

    repeat (8) next_cycle();  // Any duplicate packet would show up here
    u_checker.print_summary();
    if (!timed_out && errors == 0 && checked == TRACE_LEN && dut.u_asserts.failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== verification/rv_exec_trace.txt ====
// instr    pc       flags    result   target   mem_addr store_data
// flags: [24] illegal [20] mem_we [16] mem_re [12] redirect [8] rd_we [4:0] rd
123450B7 00000000 00000101 12345000 00000000 00000000 00000000 // lui x1, 0x12345
67808113 00000004 00000102 12345678 00000000 00000000 00000000 // addi x2, x1, 0x678
00001197 00000008 00000103 00001008 00000000 00000000 00000000 // auipc x3, 1
FFB00213 0000000C 00000104 FFFFFFFB 00000000 00000000 00000000 // addi x4, x0, -5
404102B3 00000010 00000105 1234567D 00000000 00000000 00000000 // sub x5, x2, x4
40125313 00000014 00000106 FFFFFFFD 00000000 00000000 00000000 // srai x6, x4, 1
00400413 00000018 00000108 00000004 00000000 00000000 00000000 // addi x8, x0, 4
408253B3 0000001C 00000107 FFFFFFFF 00000000 00000000 00000000 // sra x7, x4, x8
004434B3 00000020 00000109 00000001 00000000 00000000 00000000 // sltu x9, x8, x4
00822533 00000024 0000010A 00000001 00000000 00000000 00000000 // slt x10, x4, x8
007145B3 00000028 0000010B EDCBA987 00000000 00000000 00000000 // xor x11, x2, x7
00349613 0000002C 0000010C 00000008 00000000 00000000 00000000 // slli x12, x9, 3
00A48863 00000030 00001000 00000000 00000040 00000000 00000000 // beq x9, x10, +16
FE848CE3 00000034 00000000 00000000 0000002C 00000000 00000000 // beq x9, x8, -8
00849863 00000038 00001000 00000000 00000048 00000000 00000000 // bne x9, x8, +16
FEA49CE3 0000003C 00000000 00000000 00000034 00000000 00000000 // bne x9, x10, -8
00824863 00000040 00001000 00000000 00000050 00000000 00000000 // blt x4, x8, +16
FE444CE3 00000044 00000000 00000000 0000003C 00000000 00000000 // blt x8, x4, -8
00445863 00000048 00001000 00000000 00000058 00000000 00000000 // bge x8, x4, +16
FE825CE3 0000004C 00000000 00000000 00000044 00000000 00000000 // bge x4, x8, -8
00446863 00000050 00001000 00000000 00000060 00000000 00000000 // bltu x8, x4, +16
FE826CE3 00000054 00000000 00000000 0000004C 00000000 00000000 // bltu x4, x8, -8
00827863 00000058 00001000 00000000 00000068 00000000 00000000 // bgeu x4, x8, +16
FE447CE3 0000005C 00000000 00000000 00000054 00000000 00000000 // bgeu x8, x4, -8
020000EF 00000060 00001101 00000064 00000080 00000000 00000000 // jal x1, +32
003086E7 00000064 0000110D 00000068 00000066 00000000 00000000 // jalr x13, 3(x1)
00812703 00000068 00010000 00000000 00000000 12345680 00000000 // lw x14, 8(x2)
FEB1AE23 0000006C 00100000 00000000 00000000 00001004 EDCBA987 // sw x11, -4(x3)
0000000B 00000070 01000000 00000000 00000000 00000000 00000000 // custom-0, undefined
00C4E7B3 00000074 0000010F 00000009 00000000 00000000 00000000 // or x15, x9, x12
00D7F813 00000078 00000110 00000009 00000000 00000000 00000000 // andi x16, x15, 0xd
